// File: hw/i2cPkg.sv
//////////////////////////////////////////////////
// Widths, slot timing and types for the I2C master
// Bus timing is counted in ce ticks, four per bit
//////////////////////////////////////////////////
`default_nettype none

package i2cPkg;

   // Protocol widths
   localparam int AddrWidth    = 7;
   localparam int ByteWidth    = 8;
   localparam int ReadWidth    = 16;
   localparam int BitCountBits = $clog2(ByteWidth);

   // Slot timing in ce ticks
   localparam int QuarterCount  = 4;
   localparam int QuarterBits   = $clog2(QuarterCount);
   localparam int SampleQuarter = 2;
   localparam int StartTicks    = 2;
   localparam int StopTicks     = 3;

   typedef logic [AddrWidth-1:0] addr_t;
   typedef logic [ByteWidth-1:0] byte_t;
   typedef logic [ReadWidth-1:0] readWord_t;

   // One transaction, held stable while busy
   typedef struct packed {
      addr_t addr;
      logic  rw;
      byte_t wrByte;
   } i2cReq_t;

   // Driven lines, sda of 1 means released
   typedef struct packed {
      logic scl;
      logic sda;
   } busLines_t;

   typedef enum logic [1:0] {
      SlotStart,
      SlotData,
      SlotStop
   } slotKind_e;

   typedef struct packed {
      logic      go;
      slotKind_e kind;
      logic      txBit;
   } slotCmd_t;

   typedef enum logic [3:0] {
      SeqIdle,
      SeqStart,
      SeqAddr,
      SeqAddrAck,
      SeqWrite,
      SeqWriteAck,
      SeqReadHigh,
      SeqMasterAck,
      SeqReadLow,
      SeqMasterNack,
      SeqStop,
      SeqHold
   } seqState_e;

endpackage

`default_nettype wire

// File: hw/i2cByteShifter.sv
//////////////////////////////////////////////////
// Serial to parallel conversion, MSB first
// Strobes come qualified from the sequencer
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module i2cByteShifter (
   input  logic             clk,
   input  logic             rst,
   input  logic             load,
   input  i2cPkg::byte_t    loadByte,
   input  logic             shiftOut,
   input  logic             shiftIn,
   input  logic             rxBit,
   output logic             txBit,
   output i2cPkg::byte_t    rxByte
);

   i2cPkg::byte_t txReg;
   i2cPkg::byte_t rxReg;

   // Transmit side, released bits fill from the LSB
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         txReg <= '1;
      end else if (load) begin
         txReg <= loadByte;
      end else if (shiftOut) begin
         txReg <= {txReg[i2cPkg::ByteWidth-2:0], 1'b1};
      end
   end

   // Receive side
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rxReg <= '0;
      end else if (shiftIn) begin
         rxReg <= {rxReg[i2cPkg::ByteWidth-2:0], rxBit};
      end
   end

   assign txBit  = txReg[i2cPkg::ByteWidth-1];
   assign rxByte = rxReg;

endmodule

`default_nettype wire

// File: hw/i2cBitEngine.sv
//////////////////////////////////////////////////
// Runs one START, data or STOP slot on ce ticks
// A go is only taken while no slot is running
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module i2cBitEngine (
   input  logic                clk,
   input  logic                rst,
   input  logic                ce,
   input  i2cPkg::slotCmd_t    slotCmd,
   input  logic                sdaIn,
   output i2cPkg::busLines_t   bus,
   output logic                slotDone,
   output logic                sampleValid,
   output logic                rxBit
);

   logic                           active;
   logic [i2cPkg::QuarterBits-1:0] quarter;
   logic [i2cPkg::QuarterBits-1:0] lastQuarter;
   i2cPkg::slotKind_e              kind;
   logic                           sampleTick;

   // Final quarter index of each slot kind
   always_comb begin
      case (kind)
         i2cPkg::SlotStart: lastQuarter = i2cPkg::QuarterBits'(i2cPkg::StartTicks - 1);
         i2cPkg::SlotStop:  lastQuarter = i2cPkg::QuarterBits'(i2cPkg::StopTicks - 1);
         default:           lastQuarter = i2cPkg::QuarterBits'(i2cPkg::QuarterCount - 1);
      endcase
   end

   assign slotDone   = ce && active && (quarter == lastQuarter);
   assign sampleTick = ce && active && (kind == i2cPkg::SlotData) &&
                       (quarter == i2cPkg::QuarterBits'(i2cPkg::SampleQuarter));

   //////////////////////////////////////////////////
   // Waveform sequencing
   //////////////////////////////////////////////////
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active      <= 1'b0;
         quarter     <= '0;
         kind        <= i2cPkg::SlotData;
         bus         <= '{scl: 1'b1, sda: 1'b1};
         sampleValid <= 1'b0;
      end else begin
         sampleValid <= sampleTick;
         if (ce) begin
            if (!active) begin
               if (slotCmd.go) begin
                  // First quarter of the new slot
                  active  <= 1'b1;
                  kind    <= slotCmd.kind;
                  quarter <= i2cPkg::QuarterBits'(1);
                  case (slotCmd.kind)
                     i2cPkg::SlotStart: begin
                        bus.scl <= 1'b1;
                        bus.sda <= 1'b0;
                     end
                     i2cPkg::SlotStop: begin
                        bus.scl <= 1'b0;
                        bus.sda <= 1'b0;
                     end
                     default: begin
                        bus.scl <= 1'b0;
                        bus.sda <= slotCmd.txBit;
                     end
                  endcase
               end
            end else begin
               quarter <= quarter + 1'b1;
               if (quarter == lastQuarter) begin
                  active <= 1'b0;
               end
               case (kind)
                  i2cPkg::SlotStart: begin
                     bus.scl <= 1'b0;
                  end
                  i2cPkg::SlotStop: begin
                     // SCL rises first, then SDA with SCL high
                     if (quarter == lastQuarter) begin
                        bus.sda <= 1'b1;
                     end else begin
                        bus.scl <= 1'b1;
                     end
                  end
                  default: begin
                     // SCL high in the middle quarters
                     bus.scl <= (quarter != lastQuarter);
                  end
               endcase
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sampleTick) begin
         rxBit <= sdaIn;
      end
   end

endmodule

`default_nettype wire

// File: hw/i2cSequencer.sv
//////////////////////////////////////////////////
// Transaction FSM ordering START, bytes, ACKs, STOP
// Holds after STOP until start drops
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module i2cSequencer (
   input  logic                clk,
   input  logic                rst,
   input  logic                ce,
   input  logic                start,
   input  i2cPkg::i2cReq_t     req,
   input  logic                slotDone,
   input  logic                sampleValid,
   input  logic                rxBit,
   input  logic                txBit,
   input  i2cPkg::byte_t       rxByte,
   output i2cPkg::slotCmd_t    slotCmd,
   output logic                load,
   output i2cPkg::byte_t       loadByte,
   output logic                shiftOut,
   output logic                shiftIn,
   output logic                busy,
   output logic                ackBit,
   output i2cPkg::readWord_t   din
);

   i2cPkg::seqState_e               state;
   logic                            waiting;
   logic [i2cPkg::BitCountBits-1:0] bitCount;
   logic                            lastBit;
   logic                            dataBitState;
   logic                            ackSlot;
   logic                            writeAfterAddr;

   assign busy    = (state != i2cPkg::SeqIdle);
   assign lastBit = (bitCount == i2cPkg::BitCountBits'(i2cPkg::ByteWidth - 1));

   assign dataBitState = (state inside {i2cPkg::SeqAddr, i2cPkg::SeqWrite,
                                        i2cPkg::SeqReadHigh, i2cPkg::SeqReadLow});
   assign ackSlot      = (state inside {i2cPkg::SeqAddrAck, i2cPkg::SeqWriteAck});

   // Address acknowledged on a write
   assign writeAfterAddr = slotDone && (state == i2cPkg::SeqAddrAck) && !rxBit && !req.rw;

   //////////////////////////////////////////////////
   // Slot commands and shifter strobes
   //////////////////////////////////////////////////
   always_comb begin
      slotCmd = '{go: 1'b0, kind: i2cPkg::SlotData, txBit: 1'b1};
      case (state)
         i2cPkg::SeqStart:            slotCmd.kind  = i2cPkg::SlotStart;
         i2cPkg::SeqAddr,
         i2cPkg::SeqWrite:            slotCmd.txBit = txBit;
         i2cPkg::SeqMasterAck:        slotCmd.txBit = 1'b0;
         i2cPkg::SeqStop:             slotCmd.kind  = i2cPkg::SlotStop;
         default:                     slotCmd.txBit = 1'b1;
      endcase
      slotCmd.go = ce && !waiting &&
                   (state != i2cPkg::SeqIdle) && (state != i2cPkg::SeqHold);
   end

   assign load     = (ce && start && (state == i2cPkg::SeqIdle)) || writeAfterAddr;
   assign loadByte = (state == i2cPkg::SeqIdle) ? {req.addr, req.rw} : req.wrByte;
   assign shiftOut = slotDone && (state inside {i2cPkg::SeqAddr, i2cPkg::SeqWrite});
   assign shiftIn  = sampleValid &&
                     (state inside {i2cPkg::SeqReadHigh, i2cPkg::SeqReadLow});

   //////////////////////////////////////////////////
   // State register
   //////////////////////////////////////////////////
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= i2cPkg::SeqIdle;
         waiting  <= 1'b0;
         bitCount <= '0;
         ackBit   <= 1'b1;
         din      <= '0;
      end else begin
         if (slotCmd.go) begin
            waiting <= 1'b1;
         end else if (slotDone) begin
            waiting <= 1'b0;
         end

         // Wraps to zero after every full byte
         if (slotDone && dataBitState) begin
            bitCount <= bitCount + 1'b1;
         end

         if (slotDone && ackSlot) begin
            ackBit <= rxBit;
         end

         case (state)
            i2cPkg::SeqIdle: begin
               if (ce && start) begin
                  state <= i2cPkg::SeqStart;
               end
            end
            i2cPkg::SeqStart: begin
               if (slotDone) begin
                  state <= i2cPkg::SeqAddr;
               end
            end
            i2cPkg::SeqAddr: begin
               if (slotDone && lastBit) begin
                  state <= i2cPkg::SeqAddrAck;
               end
            end
            i2cPkg::SeqAddrAck: begin
               if (slotDone) begin
                  // No acknowledge goes straight to STOP
                  if (rxBit) begin
                     state <= i2cPkg::SeqStop;
                  end else if (req.rw) begin
                     state <= i2cPkg::SeqReadHigh;
                  end else begin
                     state <= i2cPkg::SeqWrite;
                  end
               end
            end
            i2cPkg::SeqWrite: begin
               if (slotDone && lastBit) begin
                  state <= i2cPkg::SeqWriteAck;
               end
            end
            i2cPkg::SeqWriteAck: begin
               if (slotDone) begin
                  state <= i2cPkg::SeqStop;
               end
            end
            i2cPkg::SeqReadHigh: begin
               if (slotDone && lastBit) begin
                  state <= i2cPkg::SeqMasterAck;
               end
            end
            i2cPkg::SeqMasterAck: begin
               if (slotDone) begin
                  din[i2cPkg::ReadWidth-1 -: i2cPkg::ByteWidth] <= rxByte;
                  state <= i2cPkg::SeqReadLow;
               end
            end
            i2cPkg::SeqReadLow: begin
               if (slotDone && lastBit) begin
                  state <= i2cPkg::SeqMasterNack;
               end
            end
            i2cPkg::SeqMasterNack: begin
               if (slotDone) begin
                  din[i2cPkg::ByteWidth-1:0] <= rxByte;
                  state <= i2cPkg::SeqStop;
               end
            end
            i2cPkg::SeqStop: begin
               if (slotDone) begin
                  state <= i2cPkg::SeqHold;
               end
            end
            i2cPkg::SeqHold: begin
               if (ce && !start) begin
                  state <= i2cPkg::SeqIdle;
               end
            end
            default: begin
               state <= i2cPkg::SeqIdle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/i2cMaster.sv
//////////////////////////////////////////////////
// Single transaction I2C master, one bit per 4 ce ticks
// bus.sda of 1 is released, so wire it open-drain
// No clock stretching. req must be stable while busy
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module i2cMaster (
   input  logic                clk,
   input  logic                rst,
   input  logic                ce,
   input  logic                en,
   input  i2cPkg::i2cReq_t     req,
   input  logic                sdaIn,
   output i2cPkg::busLines_t   bus,
   output logic                busy,
   output logic                ackBit,
   output i2cPkg::readWord_t   din
);

   logic             enReg;
   i2cPkg::slotCmd_t slotCmd;
   logic             slotDone;
   logic             sampleValid;
   logic             rxBit;
   logic             txBit;
   logic             load;
   logic             shiftOut;
   logic             shiftIn;
   i2cPkg::byte_t    loadByte;
   i2cPkg::byte_t    rxByte;

   // Request latches while idle and drops once en is released
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         enReg <= 1'b0;
      end else if (!busy && en) begin
         enReg <= 1'b1;
      end else if (busy && !en) begin
         enReg <= 1'b0;
      end
   end

   i2cSequencer u_sequencer (
      .clk         (clk),
      .rst         (rst),
      .ce          (ce),
      .start       (enReg),
      .req         (req),
      .slotDone    (slotDone),
      .sampleValid (sampleValid),
      .rxBit       (rxBit),
      .txBit       (txBit),
      .rxByte      (rxByte),
      .slotCmd     (slotCmd),
      .load        (load),
      .loadByte    (loadByte),
      .shiftOut    (shiftOut),
      .shiftIn     (shiftIn),
      .busy        (busy),
      .ackBit      (ackBit),
      .din         (din)
   );

   i2cBitEngine u_bitEngine (
      .clk         (clk),
      .rst         (rst),
      .ce          (ce),
      .slotCmd     (slotCmd),
      .sdaIn       (sdaIn),
      .bus         (bus),
      .slotDone    (slotDone),
      .sampleValid (sampleValid),
      .rxBit       (rxBit)
   );

   i2cByteShifter u_byteShifter (
      .clk      (clk),
      .rst      (rst),
      .load     (load),
      .loadByte (loadByte),
      .shiftOut (shiftOut),
      .shiftIn  (shiftIn),
      .rxBit    (rxBit),
      .txBit    (txBit),
      .rxByte   (rxByte)
   );

endmodule

`default_nettype wire

// File: sim/i2cSlaveModel.sv
//////////////////////////////////////////////////
// Behavioral I2C slave, decodes the master's drive
// Answers one address, never stretches SCL
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module i2cSlaveModel (
   input  logic                rst,
   input  logic                scl,
   input  logic                sda,
   input  i2cPkg::addr_t       answerAddr,
   input  logic                ackData,
   input  i2cPkg::readWord_t   readWord,
   output logic                sdaDrive,
   output i2cPkg::byte_t       addrByte,
   output i2cPkg::byte_t       writeByte,
   output logic [1:0]          masterAcks,
   output int                  writeCount,
   output int                  startCount,
   output int                  stopCount
);

   typedef enum logic [2:0] {
      PhaseIdle,
      PhaseAddr,
      PhaseAddrAck,
      PhaseWrite,
      PhaseWriteAck,
      PhaseRead,
      PhaseReadAck,
      PhaseDone
   } phase_e;

   phase_e        phase;
   logic          sclPrev;
   logic          sdaPrev;
   logic          matched;
   logic          ackClocked;
   logic          lowByte;
   int            bitIdx;
   i2cPkg::byte_t shiftReg;

   // Read word goes out high byte first, MSB first
   function automatic logic readBit(input logic low, input int idx);
      readBit = readWord[i2cPkg::ReadWidth - 1 - (low ? i2cPkg::ByteWidth : 0) - idx];
   endfunction

   always @(posedge scl or negedge scl or posedge sda or negedge sda or posedge rst) begin
      if (rst) begin
         phase      = PhaseIdle;
         sdaDrive   = 1'b1;
         addrByte   = '0;
         writeByte  = '0;
         masterAcks = 2'b11;
         writeCount = 0;
         startCount = 0;
         stopCount  = 0;
      end else if (scl !== sclPrev && scl === 1'b1) begin
         // Bits are taken on the SCL rise
         case (phase)
            PhaseAddr, PhaseWrite: begin
               shiftReg = {shiftReg[i2cPkg::ByteWidth-2:0], sda};
               bitIdx++;
               if (bitIdx == i2cPkg::ByteWidth) begin
                  ackClocked = 1'b0;
                  if (phase == PhaseAddr) begin
                     addrByte = shiftReg;
                     matched  = (shiftReg[i2cPkg::ByteWidth-1:1] == answerAddr);
                     phase    = PhaseAddrAck;
                  end else begin
                     writeByte = shiftReg;
                     writeCount++;
                     phase = PhaseWriteAck;
                  end
               end
            end
            PhaseRead: begin
               bitIdx++;
               if (bitIdx == i2cPkg::ByteWidth) begin
                  ackClocked = 1'b0;
                  phase      = PhaseReadAck;
               end
            end
            PhaseReadAck: begin
               masterAcks[lowByte] = sda;
               ackClocked = 1'b1;
            end
            PhaseAddrAck, PhaseWriteAck: begin
               ackClocked = 1'b1;
            end
            default: begin
            end
         endcase
      end else if (scl !== sclPrev) begin
         // Own drive only moves while SCL is low
         case (phase)
            PhaseAddrAck: begin
               if (!matched) begin
                  phase = PhaseDone;
               end else if (!ackClocked) begin
                  sdaDrive = 1'b0;
               end else if (addrByte[0]) begin
                  phase    = PhaseRead;
                  bitIdx   = 0;
                  lowByte  = 1'b0;
                  sdaDrive = readBit(1'b0, 0);
               end else begin
                  phase    = PhaseWrite;
                  bitIdx   = 0;
                  sdaDrive = 1'b1;
               end
            end
            PhaseWriteAck: begin
               if (!ackClocked) begin
                  sdaDrive = !ackData;
               end else begin
                  sdaDrive = 1'b1;
                  phase    = PhaseDone;
               end
            end
            PhaseRead: begin
               sdaDrive = readBit(lowByte, bitIdx);
            end
            PhaseReadAck: begin
               sdaDrive = 1'b1;
               if (ackClocked && !masterAcks[lowByte] && !lowByte) begin
                  lowByte  = 1'b1;
                  bitIdx   = 0;
                  phase    = PhaseRead;
                  sdaDrive = readBit(1'b1, 0);
               end else if (ackClocked) begin
                  phase = PhaseDone;
               end
            end
            default: begin
            end
         endcase
      end else if (scl === 1'b1 && sda !== sdaPrev) begin
         // SDA edge with SCL high frames the transfer
         sdaDrive = 1'b1;
         if (sda === 1'b0) begin
            startCount++;
            masterAcks = 2'b11;
            bitIdx     = 0;
            phase      = PhaseAddr;
         end else begin
            stopCount++;
            phase = PhaseIdle;
         end
      end
      sclPrev = scl;
      sdaPrev = sda;
   end

endmodule

`default_nettype wire

// File: sim/tbI2cMaster.sv
//////////////////////////////////////////////////
// Directed tests of the I2C master against a slave model
// ce is held high or strobed from a seeded $random
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbI2cMaster;

   localparam int Timeout    = 20000;
   localparam int HoldCycles = 40;

   logic              clk;
   logic              rst;
   logic              ce = 1'b1;
   logic              en;
   i2cPkg::i2cReq_t   req;
   logic              sdaIn;
   i2cPkg::busLines_t bus;
   logic              busy;
   logic              ackBit;
   i2cPkg::readWord_t din;

   // Slave controls and observations
   i2cPkg::addr_t     answerAddr;
   logic              ackData;
   i2cPkg::readWord_t readWord;
   logic              slaveSda;
   i2cPkg::byte_t     addrByte;
   i2cPkg::byte_t     writeByte;
   logic [1:0]        masterAcks;
   int                writeCount;
   int                startCount;
   int                stopCount;

   logic              ceRandom;
   integer            seed;
   integer            rnd;
   int                errors;
   int                timeouts;
   i2cPkg::byte_t     randByte;
   i2cPkg::readWord_t randWord;

   // Either side pulls the open-drain line low
   assign sdaIn = bus.sda & slaveSda;

   i2cMaster u_dut (
      .clk    (clk),
      .rst    (rst),
      .ce     (ce),
      .en     (en),
      .req    (req),
      .sdaIn  (sdaIn),
      .bus    (bus),
      .busy   (busy),
      .ackBit (ackBit),
      .din    (din)
   );

   i2cSlaveModel slave (
      .rst        (rst),
      .scl        (bus.scl),
      .sda        (bus.sda),
      .answerAddr (answerAddr),
      .ackData    (ackData),
      .readWord   (readWord),
      .sdaDrive   (slaveSda),
      .addrByte   (addrByte),
      .writeByte  (writeByte),
      .masterAcks (masterAcks),
      .writeCount (writeCount),
      .startCount (startCount),
      .stopCount  (stopCount)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk) begin
      rnd = $random(seed);
      ce <= ceRandom ? rnd[0] : 1'b1;
   end

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////
   task automatic checkBit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic checkByte(input string name, input i2cPkg::byte_t exp,
                            input i2cPkg::byte_t act);
      if (act !== exp) begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic checkWord(input string name, input i2cPkg::readWord_t exp,
                            input i2cPkg::readWord_t act);
      if (act !== exp) begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic checkCount(input string name, input int exp, input int act);
      if (act !== exp) begin
         errors++;
         $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   //////////////////////////////////////////////////
   // Bounded waits
   //////////////////////////////////////////////////
   task automatic waitBusy(input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while (busy !== level && n < Timeout) begin
         @(negedge clk);
         n++;
      end
      if (busy !== level) begin
         timeouts++;
         $display("Timeout at %0t waiting for busy to become %b", $time, level);
      end
   endtask

   task automatic waitStops(input int target);
      int n;
      n = 0;
      @(negedge clk);
      while (stopCount < target && n < Timeout) begin
         @(negedge clk);
         n++;
      end
      if (stopCount < target) begin
         timeouts++;
         $display("Timeout at %0t waiting for the slave to see a STOP", $time);
      end
   endtask

   // en drops again as soon as busy is seen
   task automatic transact(input i2cPkg::addr_t addr, input logic rw,
                           input i2cPkg::byte_t data);
      @(posedge clk);
      req <= {addr, rw, data};
      en  <= 1'b1;
      waitBusy(1'b1);
      @(posedge clk);
      en <= 1'b0;
      waitBusy(1'b0);
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////
   task automatic resetValues();
      @(negedge clk);
      checkBit("bus.scl", 1'b1, bus.scl);
      checkBit("bus.sda", 1'b1, bus.sda);
      checkBit("busy", 1'b0, busy);
      checkBit("ackBit", 1'b1, ackBit);
      checkWord("din", '0, din);
   endtask

   task automatic singleWrite(input i2cPkg::addr_t addr, input i2cPkg::byte_t data,
                              input logic ack);
      int starts;
      int stops;
      int writes;
      starts     = startCount;
      stops      = stopCount;
      writes     = writeCount;
      answerAddr = addr;
      ackData    = ack;
      transact(addr, 1'b0, data);
      checkCount("startCount", starts + 1, startCount);
      checkCount("stopCount", stops + 1, stopCount);
      checkCount("writeCount", writes + 1, writeCount);
      checkByte("addrByte", {addr, 1'b0}, addrByte);
      checkByte("writeByte", data, writeByte);
      // 0 is an acknowledge in I2C sense
      checkBit("ackBit", !ack, ackBit);
   endtask

   task automatic unansweredAddr(input i2cPkg::addr_t addr);
      int starts;
      int stops;
      int writes;
      starts     = startCount;
      stops      = stopCount;
      writes     = writeCount;
      answerAddr = ~addr;
      ackData    = 1'b1;
      transact(addr, 1'b0, 8'hA5);
      checkCount("startCount", starts + 1, startCount);
      checkCount("stopCount", stops + 1, stopCount);
      checkCount("writeCount", writes, writeCount);
      checkByte("addrByte", {addr, 1'b0}, addrByte);
      checkBit("ackBit", 1'b1, ackBit);
   endtask

   task automatic twoByteRead(input i2cPkg::addr_t addr, input i2cPkg::readWord_t word);
      int starts;
      int stops;
      starts     = startCount;
      stops      = stopCount;
      answerAddr = addr;
      readWord   = word;
      transact(addr, 1'b1, 8'h00);
      checkCount("startCount", starts + 1, startCount);
      checkCount("stopCount", stops + 1, stopCount);
      checkByte("addrByte", {addr, 1'b1}, addrByte);
      checkBit("ackBit", 1'b0, ackBit);
      checkWord("din", word, din);
      checkBit("masterAcks[0]", 1'b0, masterAcks[0]);
      checkBit("masterAcks[1]", 1'b1, masterAcks[1]);
   endtask

   task automatic holdAfterStop(input i2cPkg::addr_t addr);
      int starts;
      int stops;
      starts     = startCount;
      stops      = stopCount;
      answerAddr = addr;
      ackData    = 1'b1;
      @(posedge clk);
      req <= {addr, 1'b0, 8'h5E};
      en  <= 1'b1;
      waitBusy(1'b1);
      waitStops(stops + 1);
      repeat (HoldCycles) begin
         @(negedge clk);
         checkBit("busy", 1'b1, busy);
      end
      checkCount("startCount", starts + 1, startCount);
      @(posedge clk);
      en <= 1'b0;
      waitBusy(1'b0);
      checkCount("startCount", starts + 1, startCount);
   endtask

   initial begin
      seed       = 87382;
      errors     = 0;
      timeouts   = 0;
      ceRandom   = 1'b0;
      rst        = 1'b0;
      en         = 1'b0;
      req        = '0;
      answerAddr = '0;
      ackData    = 1'b1;
      readWord   = '0;
      @(posedge clk);
      rst <= 1'b1;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      resetValues();
      singleWrite(7'h5A, 8'hC5, 1'b1);
      singleWrite(7'h21, 8'h3A, 1'b0);
      unansweredAddr(7'h44);
      twoByteRead(7'h3B, 16'hA55A);
      holdAfterStop(7'h12);

      // Same checks with ce strobed
      @(posedge clk);
      ceRandom <= 1'b1;
      randByte = i2cPkg::byte_t'($random(seed));
      randWord = i2cPkg::readWord_t'($random(seed));
      singleWrite(7'h6E, randByte, 1'b1);
      twoByteRead(7'h09, randWord);

      $display("Errors %0d, timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: i2cMaster.f
hw/i2cPkg.sv
hw/i2cByteShifter.sv
hw/i2cBitEngine.sv
hw/i2cSequencer.sv
hw/i2cMaster.sv
sim/i2cSlaveModel.sv
sim/tbI2cMaster.sv
